//--- tb.f
logic/image_pipe_pkg.sv
logic/image_pipe.sv
logic/image_shift_buffer.sv
logic/output_reg_slice.sv
logic/image_pipe_top.sv
testbench/image_pipe_tb.sv

//--- run.sh
#!/bin/sh
# Builds the image pipe testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module image_pipe_tb \
  -o image_pipe_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/image_pipe_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

//--- testbench/image_pipe_tb.sv
module image_pipe_tb
  import image_pipe_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int BEAT_W = UNITS_EDGES * WORD_WIDTH;
  localparam int OUT_W  = UNITS * WORD_WIDTH;

  logic                   aclk = 1'b0;
  logic                   arst_n;
  logic                   in_1_valid;
  logic                   in_1_last;
  logic [BEAT_W-1:0]      in_1_data;
  logic                   in_1_ready;
  logic                   in_2_valid;
  logic [BEAT_W-1:0]      in_2_data;
  logic                   in_2_ready;
  logic                   out_ready;
  logic                   out_valid;
  logic [OUT_W-1:0]       out_1_data;
  logic [OUT_W-1:0]       out_2_data;
  logic [TUSER_WIDTH-1:0] out_user;

  logic [31:0]            rng_state = 32'h88449141;
  logic [BEAT_W:0]        in_1_q[$];
  logic [BEAT_W-1:0]      in_2_q[$];
  logic [OUT_W-1:0]       exp_1_q[$];
  logic [OUT_W-1:0]       exp_2_q[$];
  logic [TUSER_WIDTH-1:0] exp_user_q[$];
  logic                   fire_1 = 1'b0;
  logic                   fire_2 = 1'b0;
  logic                   held = 1'b0;
  logic [OUT_W-1:0]       held_1;
  logic [OUT_W-1:0]       held_2;
  logic [TUSER_WIDTH-1:0] held_user;
  int                     valid_pct = 100;
  int                     ready_pct = 100;
  int                     test_num = 0;
  int                     test_errors = 0;
  int                     total_errors = 0;
  int                     checks = 0;

  image_pipe_top DUT (.*);

  always #5 aclk = ~aclk;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic chance(input int pct);
    return (xorshift32() % 32'd100) < 32'(pct);
  endfunction

  // moves the window start to word 0, zero filling past the padded edge.
  function automatic logic [BEAT_W-1:0] decentre(input logic [BEAT_W-1:0] beat, input int h2);
    logic [BEAT_W-1:0] res;
    res = '0;
    for (int u = 0; u < UNITS_EDGES; u++) begin
      if (u <= UNITS + 2 * h2) begin
        res[u*WORD_WIDTH +: WORD_WIDTH] = beat[(u+1-h2)*WORD_WIDTH +: WORD_WIDTH];
      end
    end
    return res;
  endfunction

  // queues one frame and its expected output, and returns its input beat count.
  function automatic int queue_frame(input logic is_max, input logic lrelu,
                                     input logic [1:0] kh);
    logic [31:0]            r0;
    logic [31:0]            r1;
    logic [BEAT_W-1:0]      d1;
    logic [BEAT_W-1:0]      d2;
    logic [BEAT_W-1:0]      dec_1;
    logic [BEAT_W-1:0]      dec_2;
    logic [TUSER_WIDTH-1:0] user;
    int                     n;
    r0 = xorshift32();
    in_1_q.push_back({1'b0, r0[15:0], 6'b0, kh, 7'b0, lrelu, 7'b0, is_max, 7'b0, !is_max});
    user = {kh, lrelu, is_max, !is_max};
    n = 3 + int'(xorshift32() % 32'd6);
    for (int b = 0; b < n; b++) begin
      r0 = xorshift32();
      r1 = xorshift32();
      d1 = {r0[15:0], r1};
      r0 = xorshift32();
      r1 = xorshift32();
      d2 = {r0[15:0], r1};
      in_1_q.push_back({b == n - 1, d1});
      if (is_max) begin
        in_2_q.push_back(d2);
      end
      dec_1 = decentre(d1, int'(kh) / 2);
      dec_2 = decentre(is_max ? d2 : d1, int'(kh) / 2);
      for (int j = 0; j <= int'(kh); j++) begin
        exp_1_q.push_back(dec_1[j*WORD_WIDTH +: OUT_W]);
        exp_2_q.push_back(dec_2[j*WORD_WIDTH +: OUT_W]);
        exp_user_q.push_back(user);
      end
    end
    return n + 1;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    test_num++;
    $display("test %0d %s: %s with %0d errors", test_num, name,
             test_errors == 0 ? "ok" : "failed", test_errors);
    total_errors += test_errors;
    test_errors = 0;
  endtask

  // handshakes are sampled mid cycle, where every input and output is settled.
  always @(negedge aclk) begin
    if (arst_n) begin
      fire_1 = in_1_valid && in_1_ready;
      fire_2 = in_2_valid && in_2_ready;
      if (held) begin
        check_value("out_valid", 32'd1, 32'(out_valid));
        check_value("out_1_data", held_1, out_1_data);
        check_value("out_2_data", held_2, out_2_data);
        check_value("out_user", 32'(held_user), 32'(out_user));
      end
      held      = out_valid && !out_ready;
      held_1    = out_1_data;
      held_2    = out_2_data;
      held_user = out_user;
      if (out_valid && out_ready) begin
        assert (exp_1_q.size() != 0) else begin
          $display("output beat at %0t arrived when no beat was expected", $time);
          test_errors++;
        end
        if (exp_1_q.size() != 0) begin
          check_value("out_1_data", exp_1_q.pop_front(), out_1_data);
          check_value("out_2_data", exp_2_q.pop_front(), out_2_data);
          check_value("out_user", 32'(exp_user_q.pop_front()), 32'(out_user));
        end
      end
    end
  end

  always @(posedge aclk) begin
    if (arst_n) begin
      #1;
      if (fire_1) begin
        void'(in_1_q.pop_front());
      end
      if (fire_2) begin
        void'(in_2_q.pop_front());
      end
      if (in_1_q.size() == 0) begin
        in_1_valid = 1'b0;
      end else begin
        if (!in_1_valid || fire_1) begin
          in_1_valid = chance(valid_pct);
        end
        in_1_last = in_1_q[0][BEAT_W];
        in_1_data = in_1_q[0][BEAT_W-1:0];
      end
      if (in_2_q.size() == 0) begin
        in_2_valid = 1'b0;
      end else begin
        if (!in_2_valid || fire_2) begin
          in_2_valid = chance(valid_pct);
        end
        in_2_data = in_2_q[0];
      end
      out_ready = chance(ready_pct);
    end
  end

  // mode 0 is non-max with kernel 1, mode 1 is max with kernel 3, mode 2 is
  // random, and mode 3 walks through every config combination.
  task automatic run_test(input string name, input int mode, input int frames,
                          input int v_pct, input int r_pct);
    logic [31:0] r;
    logic [2:0]  sel;
    int          beats;
    int          limit;
    int          cycles;
    @(negedge aclk);
    #1;
    valid_pct = v_pct;
    ready_pct = r_pct;
    beats = 0;
    for (int f = 0; f < frames; f++) begin
      r = xorshift32();
      sel = (mode == 3) ? 3'(f) : r[2:0];
      case (mode)
        0:       beats += queue_frame(1'b0, sel[2], 2'd0);
        1:       beats += queue_frame(1'b1, sel[2], 2'd2);
        default: beats += queue_frame(sel[0], sel[2], sel[1] ? 2'd2 : 2'd0);
      endcase
    end
    limit = 4 * (beats * 3 + 20);
    cycles = 0;
    while (exp_1_q.size() != 0 || in_1_q.size() != 0 || in_2_q.size() != 0) begin
      @(negedge aclk);
      #1;
      cycles++;
      if (cycles >= limit) begin
        $display("run timed out in test %s with %0d output beats still missing",
                 name, exp_1_q.size());
        $display("SOME TESTS FAILED");
        $finish;
      end
    end
    // a stray extra beat shows up in these cycles.
    repeat (4) @(negedge aclk);
    #1;
    report_test(name);
  endtask

  initial begin
    arst_n     = 1'b0;
    in_1_valid = 1'b0;
    in_1_last  = 1'b0;
    in_1_data  = '0;
    in_2_valid = 1'b0;
    in_2_data  = '0;
    out_ready  = 1'b0;
    repeat (2) @(posedge aclk);
    #1;
    arst_n = 1'b1;
    check_value("out_valid", 32'd0, 32'(out_valid));
    check_value("in_2_ready", 32'd0, 32'(in_2_ready));
    check_value("in_1_ready", 32'd1, 32'(in_1_ready));
    report_test("reset state");
    run_test("non-max kernel 1", 0, 4, 100, 100);
    run_test("max kernel 3", 1, 4, 100, 100);
    run_test("random gaps and stalls", 2, 8, 60, 50);
    run_test("changing config", 3, 8, 100, 70);
    $display("%0d tests, %0d checks, %0d errors", test_num, checks, total_errors);
    if (total_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- logic/image_pipe_top.sv
module image_pipe_top
  import image_pipe_pkg::*;
(
  input  logic                              aclk,
  input  logic                              arst_n,

  input  logic                              in_1_valid,
  input  logic                              in_1_last,
  input  logic [UNITS_EDGES*WORD_WIDTH-1:0] in_1_data,
  output logic                              in_1_ready,

  input  logic                              in_2_valid,
  input  logic [UNITS_EDGES*WORD_WIDTH-1:0] in_2_data,
  output logic                              in_2_ready,

  input  logic                              out_ready,
  output logic                              out_valid,
  output logic [UNITS*WORD_WIDTH-1:0]       out_1_data,
  output logic [UNITS*WORD_WIDTH-1:0]       out_2_data,
  output logic [TUSER_WIDTH-1:0]            out_user
);

  logic                                   pipe_valid;
  logic                                   pipe_ready;
  logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] pipe_1_data;
  logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] pipe_2_data;
  logic [TUSER_WIDTH-1:0]                 pipe_user;

  logic                                   buf_valid;
  logic                                   buf_ready;
  logic [UNITS-1:0][WORD_WIDTH-1:0]       buf_1_data;
  logic [UNITS-1:0][WORD_WIDTH-1:0]       buf_2_data;
  logic [TUSER_WIDTH-1:0]                 buf_user;

  image_pipe u_pipe (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .in_1_valid  (in_1_valid),
    .in_1_last   (in_1_last),
    .in_1_data   (in_1_data),
    .in_1_ready  (in_1_ready),
    .in_2_valid  (in_2_valid),
    .in_2_data   (in_2_data),
    .in_2_ready  (in_2_ready),
    .pipe_ready  (pipe_ready),
    .pipe_valid  (pipe_valid),
    .pipe_1_data (pipe_1_data),
    .pipe_2_data (pipe_2_data),
    .pipe_user   (pipe_user)
  );

  image_shift_buffer u_shift (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .pipe_valid  (pipe_valid),
    .pipe_1_data (pipe_1_data),
    .pipe_2_data (pipe_2_data),
    .pipe_user   (pipe_user),
    .pipe_ready  (pipe_ready),
    .buf_ready   (buf_ready),
    .buf_valid   (buf_valid),
    .buf_1_data  (buf_1_data),
    .buf_2_data  (buf_2_data),
    .buf_user    (buf_user)
  );

  output_reg_slice u_slice (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .buf_valid   (buf_valid),
    .buf_1_data  (buf_1_data),
    .buf_2_data  (buf_2_data),
    .buf_user    (buf_user),
    .buf_ready   (buf_ready),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_1_data  (out_1_data),
    .out_2_data  (out_2_data),
    .out_user    (out_user)
  );

endmodule

//--- logic/output_reg_slice.sv
module output_reg_slice
  import image_pipe_pkg::*;
(
  input  logic                             aclk,
  input  logic                             arst_n,

  input  logic                             buf_valid,
  input  logic [UNITS-1:0][WORD_WIDTH-1:0] buf_1_data,
  input  logic [UNITS-1:0][WORD_WIDTH-1:0] buf_2_data,
  input  logic [TUSER_WIDTH-1:0]           buf_user,
  output logic                             buf_ready,

  input  logic                             out_ready,
  output logic                             out_valid,
  output logic [UNITS-1:0][WORD_WIDTH-1:0] out_1_data,
  output logic [UNITS-1:0][WORD_WIDTH-1:0] out_2_data,
  output logic [TUSER_WIDTH-1:0]           out_user
);

  logic                             accept;
  logic                             drain;
  logic [UNITS-1:0][WORD_WIDTH-1:0] skid_1_data;
  logic [UNITS-1:0][WORD_WIDTH-1:0] skid_2_data;
  logic [TUSER_WIDTH-1:0]           skid_user;

  // buf_ready low means the skid entry holds a beat.
  assign accept = buf_valid && buf_ready;
  assign drain  = out_ready || !out_valid;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      buf_ready <= 1'b1;
    end else if (drain) begin
      out_valid <= !buf_ready || buf_valid;
      buf_ready <= 1'b1;
    end else if (accept) begin
      buf_ready <= 1'b0;
    end
  end

  // the skid entry feeds the output first, as it holds the older beat.
  always_ff @(posedge aclk) begin
    if (drain) begin
      if (!buf_ready) begin
        out_1_data <= skid_1_data;
        out_2_data <= skid_2_data;
        out_user   <= skid_user;
      end else begin
        out_1_data <= buf_1_data;
        out_2_data <= buf_2_data;
        out_user   <= buf_user;
      end
    end
    if (accept && !drain) begin
      skid_1_data <= buf_1_data;
      skid_2_data <= buf_2_data;
      skid_user   <= buf_user;
    end
  end

  assert property (@(posedge aclk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_1_data) &&
                                $stable(out_2_data) && $stable(out_user))
    else $error("output beat changed while stalled");

endmodule

//--- logic/image_shift_buffer.sv
module image_shift_buffer
  import image_pipe_pkg::*;
(
  input  logic                                   aclk,
  input  logic                                   arst_n,

  input  logic                                   pipe_valid,
  input  logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] pipe_1_data,
  input  logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] pipe_2_data,
  input  logic [TUSER_WIDTH-1:0]                 pipe_user,
  output logic                                   pipe_ready,

  input  logic                                   buf_ready,
  output logic                                   buf_valid,
  output logic [UNITS-1:0][WORD_WIDTH-1:0]       buf_1_data,
  output logic [UNITS-1:0][WORD_WIDTH-1:0]       buf_2_data,
  output logic [TUSER_WIDTH-1:0]                 buf_user
);

  logic [BITS_KERNEL_H-1:0]               count;
  logic [BITS_KERNEL_H-1:0]               count_next;
  logic [BITS_KERNEL_H-1:0]               in_kernel_h_1;
  logic [BITS_KERNEL_H-2:0]               in_h2;
  logic                                   idle;
  logic                                   valid_next;
  logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] lane_in  [2];
  logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] lane_reg [2];

  assign in_kernel_h_1 = pipe_user[I_KERNEL_H_1 +: BITS_KERNEL_H];
  assign in_h2         = in_kernel_h_1[BITS_KERNEL_H-1:1];
  assign idle          = (count == '0);

  assign lane_in[0] = pipe_1_data;
  assign lane_in[1] = pipe_2_data;

  // while a beat is being shifted out the input stays blocked, and the
  // output is always valid.
  always_comb begin
    if (idle) begin
      pipe_ready = buf_ready;
      valid_next = pipe_valid;
      count_next = pipe_valid ? in_kernel_h_1 : '0;
    end else begin
      pipe_ready = 1'b0;
      valid_next = 1'b1;
      count_next = count - 1'b1;
    end
  end

  // everything here advances only when the slice can take a beat.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      count     <= '0;
      buf_valid <= 1'b0;
    end else if (buf_ready) begin
      count     <= count_next;
      buf_valid <= valid_next;
    end
  end

  always_ff @(posedge aclk) begin
    if (buf_ready && idle) begin
      buf_user <= pipe_user;
    end
  end

  for (genvar lane = 0; lane < 2; lane++) begin : g_lane
    logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] dec_opt [KERNEL_H_MAX/2+1];
    logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] dec;

    // the input is padded around its centre but the buffer shifts one way
    // only, so the window start moves to word 0 before loading.
    for (genvar h2 = 0; h2 <= KERNEL_H_MAX/2; h2++) begin : g_h2
      for (genvar u = 0; u < UNITS_EDGES; u++) begin : g_word
        if (u <= UNITS + 2*h2) begin : g_take
          assign dec_opt[h2][u] = lane_in[lane][u + KERNEL_H_MAX/2 - h2];
        end else begin : g_zero
          assign dec_opt[h2][u] = '0;
        end
      end
    end

    assign dec = dec_opt[in_h2];

    // the top word keeps its value, lower words take their upper neighbour.
    always_ff @(posedge aclk) begin
      if (buf_ready) begin
        if (idle) begin
          lane_reg[lane] <= dec;
        end else begin
          lane_reg[lane] <= {lane_reg[lane][UNITS_EDGES-1],
                             lane_reg[lane][UNITS_EDGES-1:1]};
        end
      end
    end
  end

  assign buf_1_data = lane_reg[0][UNITS-1:0];
  assign buf_2_data = lane_reg[1][UNITS-1:0];

  // a new beat may only enter once the previous one has been fully shifted.
  assert property (@(posedge aclk) disable iff (!arst_n)
    pipe_valid && pipe_ready && (in_kernel_h_1 != '0) |=> !pipe_ready)
    else $error("shift buffer ready while %0d shifts remain", count);

endmodule

//--- logic/image_pipe.sv
module image_pipe
  import image_pipe_pkg::*;
(
  input  logic                                   aclk,
  input  logic                                   arst_n,

  input  logic                                   in_1_valid,
  input  logic                                   in_1_last,
  input  in_beat_u                               in_1_data,
  output logic                                   in_1_ready,

  input  logic                                   in_2_valid,
  input  logic [UNITS_EDGES*WORD_WIDTH-1:0]      in_2_data,
  output logic                                   in_2_ready,

  input  logic                                   pipe_ready,
  output logic                                   pipe_valid,
  output logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] pipe_1_data,
  output logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] pipe_2_data,
  output logic [TUSER_WIDTH-1:0]                 pipe_user
);

  logic                     state;
  logic                     load_config;
  logic                     in_1_end;
  logic                     is_not_max;
  logic                     is_max;
  logic                     is_lrelu;
  logic [BITS_KERNEL_H-1:0] kernel_h_1;

  // in SET every beat on input 1 is taken as the frame header.
  assign load_config = (state == ST_SET) && in_1_valid;
  assign in_1_end    = (state == ST_PASS) && in_1_valid && in_1_ready && in_1_last;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_SET;
    end else if (load_config) begin
      state <= ST_PASS;
    end else if (in_1_end) begin
      state <= ST_SET;
    end
  end

  // only bit 0 of each flag word is meaningful.
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      is_not_max <= 1'b0;
      is_max     <= 1'b0;
      is_lrelu   <= 1'b0;
      kernel_h_1 <= '0;
    end else if (load_config) begin
      is_not_max <= in_1_data.cfg.is_not_max[0];
      is_max     <= in_1_data.cfg.is_max[0];
      is_lrelu   <= in_1_data.cfg.is_lrelu[0];
      kernel_h_1 <= in_1_data.cfg.kernel_h_1[BITS_KERNEL_H-1:0];
    end
  end

  // handshake routing. In max mode both inputs move together, so each
  // side only sees ready when the other side has data too.
  always_comb begin
    if (state == ST_SET) begin
      pipe_valid = 1'b0;
      in_1_ready = 1'b1;
      in_2_ready = 1'b0;
    end else if (is_max) begin
      pipe_valid = in_1_valid && in_2_valid;
      in_1_ready = pipe_ready && in_2_valid;
      in_2_ready = pipe_ready && in_1_valid;
    end else begin
      pipe_valid = in_1_valid;
      in_1_ready = pipe_ready;
      in_2_ready = 1'b0;
    end
  end

  // channel 2 follows input 2 only for max pooling.
  assign pipe_1_data = in_1_data.words;
  assign pipe_2_data = is_max ? in_2_data : in_1_data.words;

  assign pipe_user[I_IS_NOT_MAX]                  = is_not_max;
  assign pipe_user[I_IS_MAX]                      = is_max;
  assign pipe_user[I_IS_LRELU]                    = is_lrelu;
  assign pipe_user[I_KERNEL_H_1 +: BITS_KERNEL_H] = kernel_h_1;

  // the shift buffer only handles odd kernel heights up to the maximum.
  assert property (@(posedge aclk) disable iff (!arst_n)
    load_config |-> (in_1_data.cfg.kernel_h_1 <= KERNEL_H_MAX - 1) &&
                    !in_1_data.cfg.kernel_h_1[0])
    else $error("config beat with unsupported kernel_h_1 %0d",
                in_1_data.cfg.kernel_h_1);

endmodule

//--- logic/image_pipe_pkg.sv
package image_pipe_pkg;

  // pixel geometry of one input and one output beat.
  localparam int WORD_WIDTH   = 8;
  localparam int UNITS        = 4;
  localparam int KERNEL_H_MAX = 3;
  localparam int EDGES        = KERNEL_H_MAX - 1;
  localparam int UNITS_EDGES  = UNITS + EDGES;

  // kernel_h_1 is 0 or 2 and fits in two bits.
  localparam int BITS_KERNEL_H = $clog2(KERNEL_H_MAX);

  // positions of the config fields in the sideband word.
  localparam int I_IS_NOT_MAX = 0;
  localparam int I_IS_MAX     = 1;
  localparam int I_IS_LRELU   = 2;
  localparam int I_KERNEL_H_1 = 3;
  localparam int TUSER_WIDTH  = I_KERNEL_H_1 + BITS_KERNEL_H;

  // frame states of image_pipe.
  localparam logic ST_SET  = 1'b0;
  localparam logic ST_PASS = 1'b1;

  // word 0 sits in the lowest bits, so the last struct member is word 0.
  typedef struct packed {
    logic [WORD_WIDTH-1:0] pad_1;
    logic [WORD_WIDTH-1:0] pad_0;
    logic [WORD_WIDTH-1:0] kernel_h_1;
    logic [WORD_WIDTH-1:0] is_lrelu;
    logic [WORD_WIDTH-1:0] is_max;
    logic [WORD_WIDTH-1:0] is_not_max;
  } config_header_t;

  // the first beat of a frame is a config header, every later one is pixels.
  typedef union packed {
    logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] words;
    config_header_t                         cfg;
  } in_beat_u;

endpackage
